/* sim.f */
+incdir+testbench
common/nnTypes.sv
common/busTypes.sv
layer/neuronNode.sv
layer/denseLayer.sv
layer/layerRegisters.sv
logic/nnLayerTop.sv
testbench/nnLayerTb.sv

/* run.sh */
#!/bin/sh
# Build and run the layer testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module nnLayerTb -f sim.f -Mdir obj_dir -o simv
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/simv)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL CHECKS PASSED"; then
	exit 0
fi
exit 1

/* testbench/nnLayerModel.svh */
`ifndef NN_LAYER_MODEL_SVH
`define NN_LAYER_MODEL_SVH

// shadow copy of every operand the testbench has written.
logic [31:0] modelActivation [16];
logic [31:0] modelWeight [16][16];
logic [31:0] modelBias [16];

// wrapped sum, then zero when bit 31 is set, otherwise bits 28 to 13.
function automatic logic [31:0] modelResult(input int n);
	logic signed [31:0] sum;
	logic signed [31:0] product;
	sum = modelBias[n];
	for (int i = 0; i < NumInputs; i++)
	begin
		product = $signed(modelActivation[i]) * $signed(modelWeight[n][i]);
		sum = sum + product;	// both steps keep only the low word.
	end
	if (sum[31])
	begin
		return 32'd0;
	end
	return {16'd0, sum[28:13]};
endfunction

function automatic logic [9:0] inputAddress(input int i);
	return {RegionInput, 4'd0, 4'(i)};
endfunction

function automatic logic [9:0] weightAddress(input int n, input int i);
	return {RegionWeight, 4'(n), 4'(i)};
endfunction

function automatic logic [9:0] biasAddress(input int n);
	return {RegionBias, 4'd0, 4'(n)};
endfunction

function automatic logic [9:0] resultAddress(input int n);
	return {RegionControl, ResultBase + 8'(n)};
endfunction

// The request stays up through the edge that ends the ack cycle, where a write lands.
task automatic busAccess(input logic write, input logic [9:0] wordAddress,
	input logic [31:0] writeValue, output logic [31:0] readValue);
	int waited;
	waited = 0;
	request = '{cyc: 1'b1, stb: 1'b1, we: write, address: wordAddress, writeData: writeValue};
	@(negedge clk);
	while (!response.ack && waited < AckLimit)
	begin
		waited++;
		@(negedge clk);
	end
	if (!response.ack)
	begin
		$display("no ack from address %h after %0d cycles", wordAddress, AckLimit);
		errorCount++;
	end
	readValue = response.readData;
	@(negedge clk);
	request = '0;
endtask

task automatic busWrite(input logic [9:0] wordAddress, input logic [31:0] value);
	logic [31:0] ignored;
	busAccess(1'b1, wordAddress, value, ignored);
endtask

task automatic busRead(input logic [9:0] wordAddress, output logic [31:0] value);
	busAccess(1'b0, wordAddress, 32'd0, value);
endtask

`endif

/* testbench/nnLayerTb.sv */
`timescale 1ns/1ps
`default_nettype none

// Random layer runs over the Wishbone port, checked against a shadow model.
module nnLayerTb;
	import busTypes::*;

	localparam int NumInputs = 15;
	localparam int NumNeurons = 4;
	localparam int NumRuns = 30;
	localparam int AckLimit = 8;
	localparam int PollLimit = 10;
	localparam int OperandWords = NumInputs + NumNeurons * NumInputs + NumNeurons;
	localparam int RunAccesses = OperandWords + 2 + PollLimit + NumNeurons;
	localparam int WatchdogCycles = (NumRuns + 5) * RunAccesses * 10 + 200;
	localparam logic [9:0] CtrlAddress = {RegionControl, CtrlIndex};
	localparam logic [9:0] StatusAddress = {RegionControl, StatusIndex};

	logic clk;
	logic reset;
	wbRequestT request;
	wbResponseT response;
	integer seed;
	int errorCount;
	int checkCount;
	int testErrors;
	logic [31:0] readValue;

	`include "nnLayerModel.svh"

	nnLayerTop dut0 (
		.clk(clk),
		.reset(reset),
		.request(request),
		.response(response)
	);

	always #10 clk = ~clk;

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		checkCount++;
		assert (got == expected)
		else
		begin
			$display("FAIL %s got %h expected %h", name, got, expected);
			errorCount++;
		end
	endtask

	// sign 1 forces non-negative, -1 forces non-positive, 0 leaves it mixed.
	function automatic logic [31:0] drawValue(input int limit, input int sign);
		int value;
		value = $random(seed) % (limit + 1);
		if ((sign > 0 && value < 0) || (sign < 0 && value > 0))
		begin
			value = -value;
		end
		return value;
	endfunction

	// mode 1 is all positive, mode 2 all negative weights, mode 3 full-range weights.
	task automatic loadOperands(input int mode);
		int sign;
		sign = (mode == 1) ? 1 : ((mode == 2) ? -1 : 0);
		for (int i = 0; i < NumInputs; i++)
		begin
			modelActivation[i] = drawValue(16383, (sign == 0) ? 0 : 1);
			busWrite(inputAddress(i), modelActivation[i]);
		end
		for (int n = 0; n < NumNeurons; n++)
		begin
			for (int i = 0; i < NumInputs; i++)
			begin
				modelWeight[n][i] = (mode == 3) ? $random(seed) : drawValue(8192, sign);
				busWrite(weightAddress(n, i), modelWeight[n][i]);
			end
			modelBias[n] = drawValue(65535, sign);
			busWrite(biasAddress(n), modelBias[n]);
		end
	endtask

	task automatic checkOperands();
		logic [31:0] value;
		for (int i = 0; i < NumInputs; i++)
		begin
			busRead(inputAddress(i), value);
			checkValue($sformatf("activation[%0d]", i), value, modelActivation[i]);
		end
		for (int n = 0; n < NumNeurons; n++)
		begin
			for (int i = 0; i < NumInputs; i++)
			begin
				busRead(weightAddress(n, i), value);
				checkValue($sformatf("weight[%0d][%0d]", n, i), value, modelWeight[n][i]);
			end
			busRead(biasAddress(n), value);
			checkValue($sformatf("bias[%0d]", n), value, modelBias[n]);
		end
	endtask

	task automatic checkResults();
		logic [31:0] value;
		for (int n = 0; n < NumNeurons; n++)
		begin
			busRead(resultAddress(n), value);
			checkValue($sformatf("result[%0d]", n), value, modelResult(n));
		end
	endtask

	task automatic waitDone();
		logic [31:0] status;
		int polls;
		status = '0;
		polls = 0;
		while (!status[1] && polls < PollLimit)
		begin
			busRead(StatusAddress, status);
			polls++;
		end
		if (!status[1])
		begin
			$display("layer never reported done within %0d status reads", PollLimit);
			errorCount++;
		end
	endtask

	task automatic reportTest(input string name, input int errorsBefore);
		if (errorCount == errorsBefore)
		begin
			$display("test %s: ok", name);
		end
		else
		begin
			$display("test %s: %0d errors", name, errorCount - errorsBefore);
		end
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		request = '0;
		seed = 32'ha7a4_4954;
		errorCount = 0;
		checkCount = 0;
		modelActivation = '{default: '0};
		modelWeight = '{default: '0};
		modelBias = '{default: '0};
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		testErrors = errorCount;
		busRead(StatusAddress, readValue);
		checkValue("status", readValue, 32'd0);
		checkResults();
		checkOperands();
		reportTest("reset values", testErrors);

		testErrors = errorCount;
		loadOperands(0);
		checkOperands();
		busRead({RegionControl, 8'd5}, readValue);
		checkValue("unused[005]", readValue, 32'd0);
		busRead({RegionInput, 8'd15}, readValue);
		checkValue("unused[10f]", readValue, 32'd0);
		reportTest("register readback", testErrors);

		testErrors = errorCount;
		for (int r = 0; r < NumRuns; r++)
		begin
			loadOperands(r % 4);
			busWrite(CtrlAddress, 32'd1);
			waitDone();
			checkResults();
		end
		reportTest("layer results", testErrors);

		// done lands 5 cycles after the start ack and reads are 2 cycles apart.
		testErrors = errorCount;
		loadOperands(3);
		busWrite(CtrlAddress, 32'd1);
		busRead(StatusAddress, readValue);
		checkValue("status.busy", 32'(readValue[0]), 32'd1);
		repeat (2) busRead(StatusAddress, readValue);
		checkValue("status.done", 32'(readValue[1]), 32'd1);
		checkResults();
		reportTest("status timing", testErrors);

		testErrors = errorCount;
		loadOperands(0);
		busWrite(CtrlAddress, 32'd1);
		busWrite(inputAddress(0), modelActivation[0] + 32'd4096);	// lands while busy.
		waitDone();
		checkResults();
		busRead(inputAddress(0), readValue);
		checkValue("activation[0]", readValue, modelActivation[0]);
		reportTest("write while busy", testErrors);

		$display("checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0)
		begin
			$display("ALL CHECKS PASSED");
		end
		else
		begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	initial
	begin
		repeat (WatchdogCycles) @(posedge clk);
		$display("watchdog expired after %0d cycles", WatchdogCycles);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* logic/nnLayerTop.sv */
`timescale 1ns/1ps
`default_nettype none

// Dense layer with a Wishbone classic register port.
module nnLayerTop #(
	parameter int NumInputs = 15,
	parameter int NumNeurons = 4
) (
	input wire logic clk,
	input wire logic reset,
	input wire busTypes::wbRequestT request,
	output busTypes::wbResponseT response
);
	import nnTypes::*;

	activationT [NumInputs-1:0] activations;
	weightT [NumNeurons-1:0][NumInputs-1:0] weights;
	weightT [NumNeurons-1:0] biases;
	resultT [NumNeurons-1:0] results;
	logic start;
	logic resultValid;

	layerRegisters #(
		.NumInputs(NumInputs),
		.NumNeurons(NumNeurons)
	) registers0 (
		.clk(clk),
		.reset(reset),
		.request(request),
		.response(response),
		.activations(activations),
		.weights(weights),
		.biases(biases),
		.start(start),
		.results(results),
		.resultValid(resultValid)
	);

	denseLayer #(
		.NumInputs(NumInputs),
		.NumNeurons(NumNeurons)
	) layer0 (
		.clk(clk),
		.reset(reset),
		.start(start),
		.activations(activations),
		.weights(weights),
		.biases(biases),
		.results(results),
		.resultValid(resultValid)
	);

endmodule

`default_nettype wire

/* layer/layerRegisters.sv */
`timescale 1ns/1ps
`default_nettype none

// Wishbone classic slave holding the layer operands, run control and captured results.
// A transfer completes on the clock edge that ends the ack cycle.
module layerRegisters #(
	parameter int NumInputs = 15,
	parameter int NumNeurons = 4
) (
	input wire logic clk,
	input wire logic reset,
	input wire busTypes::wbRequestT request,
	output busTypes::wbResponseT response,
	output nnTypes::activationT [NumInputs-1:0] activations,
	output nnTypes::weightT [NumNeurons-1:0][NumInputs-1:0] weights,
	output nnTypes::weightT [NumNeurons-1:0] biases,
	output logic start,
	input wire nnTypes::resultT [NumNeurons-1:0] results,
	input wire logic resultValid
);
	import busTypes::*;
	import nnTypes::*;

	regAddressU address;
	logic access;
	logic ack;
	logic writeFire;
	logic [3:0] lowIndex;
	logic [3:0] neuronSlot;
	logic [3:0] inputSlot;
	logic inputHit;
	logic weightHit;
	logic biasHit;
	logic resultHit;
	logic statusHit;
	logic ctrlHit;
	logic startAccept;
	logic busy;
	logic done;
	logic [DataBits-1:0] readData;
	resultT [NumNeurons-1:0] resultStore;

	assign address = request.address;
	assign access = request.cyc && request.stb;
	assign writeFire = access && request.we && ack;	// master holds the request through ack.

	assign lowIndex = address.controlView.index[3:0];
	assign neuronSlot = address.weightView.neuronIndex;
	assign inputSlot = address.weightView.inputIndex;

	// address decode, anything outside these windows reads as zero.
	assign inputHit = address.controlView.region == RegionInput
		&& address.controlView.index[7:4] == 4'd0
		&& int'(lowIndex) < NumInputs;
	assign weightHit = address.weightView.region == RegionWeight
		&& int'(neuronSlot) < NumNeurons
		&& int'(inputSlot) < NumInputs;
	assign biasHit = address.controlView.region == RegionBias
		&& address.controlView.index[7:4] == 4'd0
		&& int'(lowIndex) < NumNeurons;
	assign resultHit = address.controlView.region == RegionControl
		&& address.controlView.index[7:4] == ResultBase[7:4]
		&& int'(lowIndex) < NumNeurons;
	assign statusHit = address.controlView.region == RegionControl
		&& address.controlView.index == StatusIndex;
	assign ctrlHit = address.controlView.region == RegionControl
		&& address.controlView.index == CtrlIndex;

	assign startAccept = writeFire && ctrlHit && request.writeData[0] && !busy && !start;

	// operand storage, frozen while the layer is running.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			activations <= '0;
			weights <= '0;
			biases <= '0;
		end
		else if (writeFire && !busy)
		begin
			if (inputHit)
			begin
				activations[lowIndex] <= request.writeData;
			end
			if (weightHit)
			begin
				weights[neuronSlot][inputSlot] <= request.writeData;
			end
			if (biasHit)
			begin
				biases[lowIndex] <= request.writeData;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ack <= 1'b0;
			start <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			ack <= access && !ack;	// one cycle, then a gap before the next.
			start <= startAccept;
			if (start)
			begin
				busy <= 1'b1;
			end
			else if (resultValid)
			begin
				busy <= 1'b0;
			end
			if (startAccept)
			begin
				done <= 1'b0;	// a new run hides the old result flag.
			end
			else if (resultValid)
			begin
				done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			resultStore <= '0;
		end
		else if (resultValid)
		begin
			resultStore <= results;
		end
	end

	// read data is decoded during the ack cycle from the held address.
	always_comb
	begin
		readData = '0;
		if (inputHit)
		begin
			readData = activations[lowIndex];
		end
		else if (weightHit)
		begin
			readData = weights[neuronSlot][inputSlot];
		end
		else if (biasHit)
		begin
			readData = biases[lowIndex];
		end
		else if (resultHit)
		begin
			readData = resultStore[lowIndex];
		end
		else if (statusHit)
		begin
			readData = {30'd0, done, busy};
		end
	end

	assign response = '{ack: ack, readData: readData};

	ackGapCheck: assert property (@(posedge clk) disable iff (reset) ack |=> !ack);

	// a second start inside a run would retire the first run's valid early.
	startIdleCheck: assert property (@(posedge clk) disable iff (reset) start |-> !busy);

endmodule

`default_nettype wire

/* layer/denseLayer.sv */
`timescale 1ns/1ps
`default_nettype none

// A row of neurons that share the activations, with a valid pipe that tracks
// which output cycle belongs to the operands present at start.
module denseLayer #(
	parameter int NumInputs = 15,
	parameter int NumNeurons = 4
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic start,
	input wire nnTypes::activationT [NumInputs-1:0] activations,
	input wire nnTypes::weightT [NumNeurons-1:0][NumInputs-1:0] weights,
	input wire nnTypes::weightT [NumNeurons-1:0] biases,
	output nnTypes::resultT [NumNeurons-1:0] results,
	output logic resultValid
);
	import nnTypes::*;

	logic [PipeDepth-1:0] validPipe;

	genvar n;
	generate
		for (n = 0; n < NumNeurons; n++)
		begin : nodes
			neuronNode #(
				.NumInputs(NumInputs)
			) node (
				.clk(clk),
				.reset(reset),
				.activations(activations),	// every node sees the same inputs.
				.weights(weights[n]),
				.bias(biases[n]),
				.result(results[n])
			);
		end
	endgenerate

	// the nodes never stall, so a plain shift register matches their latency.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validPipe <= '0;
		end
		else
		begin
			validPipe <= {validPipe[PipeDepth-2:0], start};
		end
	end

	assign resultValid = validPipe[PipeDepth-1];

	// ties the output marker back to the request that caused it.
	validLatencyCheck: assert property (@(posedge clk) disable iff (reset)
		resultValid |-> $past(start, PipeDepth));

endmodule

`default_nettype wire

/* layer/neuronNode.sv */
`timescale 1ns/1ps
`default_nettype none

// One neuron. A free-running three stage pipeline that takes new operands every clock,
// so results for older operands stay in flight while new ones are loaded.
module neuronNode #(
	parameter int NumInputs = 15
) (
	input wire logic clk,
	input wire logic reset,
	input wire nnTypes::activationT [NumInputs-1:0] activations,
	input wire nnTypes::weightT [NumInputs-1:0] weights,
	input wire nnTypes::weightT bias,
	output nnTypes::resultT result
);
	import nnTypes::*;

	activationT [NumInputs-1:0] activationReg;
	weightT [NumInputs-1:0] weightReg;
	weightT biasReg;
	logic [31:0] sumNext;
	logic [31:0] sumReg;

	// stage 1 holds the operands.
	always_ff @(posedge clk)
	begin
		activationReg <= activations;
		weightReg <= weights;
		biasReg <= bias;
	end

	// products keep only their low word, and the adder wraps like the reference node.
	always_comb
	begin
		sumNext = biasReg;
		for (int i = 0; i < NumInputs; i++)
		begin
			sumNext = sumNext + 32'($signed(activationReg[i]) * $signed(weightReg[i]));
		end
	end

	// stage 2 holds the sum and stage 3 the rescaled relu.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sumReg <= '0;
			result <= '0;
		end
		else
		begin
			sumReg <= sumNext;
			if (sumReg[31])
			begin
				result <= '0;	// negative sums clamp to zero.
			end
			else
			begin
				result <= resultT'(sumReg[FracBits+OutBits-1:FracBits]);
			end
		end
	end

	// the rescale truncates, so nothing may ever leak above the kept field.
	resultFieldCheck: assert property (@(posedge clk) disable iff (reset)
		result[31:OutBits] == '0);

endmodule

`default_nettype wire

/* common/busTypes.sv */
`default_nettype none

// Wishbone classic bus structs and the register map of the layer.
package busTypes;

	localparam int AddressBits = 10;	// word address, no byte lanes.
	localparam int DataBits = 32;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [AddressBits-1:0] address;
		logic [DataBits-1:0] writeData;
	} wbRequestT;

	typedef struct packed {
		logic ack;
		logic [DataBits-1:0] readData;
	} wbResponseT;

	typedef struct packed {
		logic [1:0] region;
		logic [3:0] neuronIndex;
		logic [3:0] inputIndex;
	} weightViewT;

	typedef struct packed {
		logic [1:0] region;
		logic [7:0] index;
	} controlViewT;

	// the weight region splits the index into neuron and input, the rest use one flat index.
	typedef union packed {
		weightViewT weightView;
		controlViewT controlView;
	} regAddressU;

	localparam logic [1:0] RegionControl = 2'd0;	// control, status and results.
	localparam logic [1:0] RegionInput = 2'd1;
	localparam logic [1:0] RegionWeight = 2'd2;
	localparam logic [1:0] RegionBias = 2'd3;

	localparam logic [7:0] CtrlIndex = 8'd0;	// bit 0 starts a run.
	localparam logic [7:0] StatusIndex = 8'd1;	// bit 0 busy, bit 1 done.
	localparam logic [7:0] ResultBase = 8'd16;

endpackage

`default_nettype wire

/* common/nnTypes.sv */
`default_nettype none

// Fixed-point types and rescale constants shared by the neuron datapath.
package nnTypes;

	// activations are stored as raw words and are read as signed by the multiplier.
	typedef logic [31:0] activationT;

	// weights and biases use the same signed word.
	typedef logic signed [31:0] weightT;

	// a neuron output, with only the low OutBits able to be nonzero.
	typedef logic [31:0] resultT;

	localparam int FracBits = 13;	// fraction bits dropped by the rescale.
	localparam int OutBits = 16;	// width of the kept field.

	// operand, sum and relu stages of each node.
	localparam int PipeDepth = 3;

endpackage

`default_nettype wire
